// ==== cache_controller.sv ====
/*
 * execute stage: idle, write-back, fetch and flush FSM,
 * word, set and way counters, memory strobes and addresses
 */
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  logic                                          proc_ren,
    input  logic                                          proc_wen,
    input  cache_geom_pkg::word_t                         proc_addr,
    input  cache_geom_pkg::byte_en_t                      proc_byte_en,
    input  logic                                          flush,
    input  logic                                          hit,
    input  logic                                          pass_through,
    input  logic                                          victim_dirty,
    input  logic                                          mem_busy,
    input  cache_geom_pkg::way_t                          victim_way,
    input  cache_geom_pkg::tag_t                          victim_tag,
    input  cache_geom_pkg::tag_t                          req_tag,
    input  cache_geom_pkg::set_idx_t                      set_idx,
    input  logic [cache_geom_pkg::N_WAYS-1:0]             frame_valid,
    input  logic [cache_geom_pkg::N_WAYS-1:0]             frame_dirty,
    input  cache_geom_pkg::tag_t [cache_geom_pkg::N_WAYS-1:0] frame_tag,
    output cache_ctrl_pkg::ctrl_state_t                   state,
    output cache_ctrl_pkg::mem_op_t                       mem_op,
    output logic                                          mem_ren,
    output logic                                          mem_wen,
    output cache_geom_pkg::word_t                         mem_addr,
    output cache_geom_pkg::byte_en_t                      mem_byte_en,
    output logic                                          array_we,
    output cache_geom_pkg::set_idx_t                      array_set,
    output cache_geom_pkg::way_t                          fill_way,
    output cache_geom_pkg::tag_t                          fill_tag,
    output cache_geom_pkg::word_off_t                     word_num,
    output logic                                          touch,
    output logic                                          proc_busy,
    output logic                                          flush_done
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam logic [BYTE_OFF_BITS-1:0] NO_BYTE_OFF = '0;

    ctrl_state_t next_state;
    logic        sweeping;      // reset sweep, frame contents are not valid yet
    set_idx_t    flush_set;
    way_t        flush_way;
    set_idx_t    miss_set;
    way_t        miss_way;
    tag_t        wb_tag;
    logic        req, miss, last_word;
    logic        word_adv, frame_done, set_done;

    assign req       = proc_ren | proc_wen;
    assign miss      = req & ~hit & ~pass_through & ~flush;
    assign last_word = (word_num == word_off_t'(BLOCK_WORDS - 1));

    assign array_set = (state == FLUSH) ? flush_set :
                       (state == IDLE)  ? set_idx : miss_set;
    assign fill_way  = (state == FLUSH) ? flush_way : miss_way;

    always_comb begin
        next_state  = state;
        mem_op      = MEM_NONE;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_byte_en = '1;
        array_we    = 1'b0;
        touch       = 1'b0;
        proc_busy   = 1'b1;
        flush_done  = 1'b0;
        word_adv    = 1'b0;
        frame_done  = 1'b0;
        set_done    = 1'b0;
        unique case (state)
            IDLE: begin
                proc_busy = req;
                if (flush) begin
                    next_state = FLUSH;
                end else if (pass_through) begin
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_byte_en = proc_byte_en;
                    mem_op      = proc_wen ? MEM_WRITE : (proc_ren ? MEM_READ : MEM_NONE);
                    proc_busy   = req & mem_busy;
                end else if (hit) begin
                    proc_busy = 1'b0;           // done in the request cycle
                    touch     = req;
                    array_we  = proc_wen;
                end else if (miss) begin
                    next_state = victim_dirty ? WRITE_BACK : FETCH;
                end
            end
            WRITE_BACK: begin
                mem_wen  = 1'b1;
                mem_op   = MEM_WRITE;
                mem_addr = {wb_tag, miss_set, word_num, NO_BYTE_OFF};
                if (!mem_busy) begin
                    word_adv = 1'b1;
                    if (last_word) begin
                        next_state = FETCH;
                    end
                end
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_op   = MEM_READ;
                mem_addr = {fill_tag, miss_set, word_num, NO_BYTE_OFF};
                if (!mem_busy) begin
                    word_adv = 1'b1;
                    array_we = 1'b1;            // each returned word goes straight in
                    if (last_word) begin
                        next_state = IDLE;
                    end
                end
            end
            FLUSH: begin
                if (sweeping || !(frame_valid[flush_way] && frame_dirty[flush_way])) begin
                    frame_done = 1'b1;          // nothing to write back
                end else begin
                    mem_wen  = 1'b1;
                    mem_op   = MEM_WRITE;
                    mem_addr = {frame_tag[flush_way], flush_set, word_num, NO_BYTE_OFF};
                    if (!mem_busy) begin
                        word_adv   = 1'b1;
                        frame_done = last_word;
                    end
                end
                // whole set is invalidated at once when its last way is done
                set_done = frame_done & (sweeping | (flush_way == way_t'(N_WAYS - 1)));
                array_we = set_done;
                if (set_done && (flush_set == set_idx_t'(N_SETS - 1))) begin
                    next_state = IDLE;
                    flush_done = ~sweeping;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= FLUSH;
            sweeping  <= 1'b1;
            word_num  <= '0;
            flush_set <= '0;
            flush_way <= '0;
        end else begin
            state <= next_state;
            if (next_state == IDLE) begin
                sweeping <= 1'b0;
            end
            if (word_adv) begin
                word_num <= word_num + 1'b1;    // wraps back to 0 after the last word
            end
            if (set_done) begin
                flush_way <= '0;
                flush_set <= flush_set + 1'b1;
            end else if (frame_done) begin
                flush_way <= flush_way + 1'b1;
            end
        end
    end

    // miss bookkeeping, captured when leaving IDLE
    always_ff @(posedge CLK) begin
        if ((state == IDLE) && miss) begin
            miss_set <= set_idx;
            miss_way <= victim_way;
            fill_tag <= req_tag;
            wb_tag   <= victim_tag;
        end
    end

endmodule

`default_nettype wire

// ==== cache_ctrl_pkg.sv ====
/*
 * controller state encoding and memory operation codes
 */
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WRITE_BACK = 2'd1,
        FETCH      = 2'd2,
        FLUSH      = 2'd3   // also used for the sweep after reset
    } ctrl_state_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_t;

endpackage

`default_nettype wire

// ==== cache_data_array.sv ====
/*
 * frame storage: valid, dirty, tag and block data per way,
 * asynchronous read, masked synchronous write
 */
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
    input  logic                      CLK,
    input  cache_geom_pkg::set_idx_t  set_idx,
    input  logic                      we,
    input  cache_geom_pkg::frames_t   wr_frame,
    input  cache_geom_pkg::frames_t   wr_mask,
    output cache_geom_pkg::frames_t   rd_frame
);
    import cache_geom_pkg::*;

    frames_t sets [N_SETS];

    assign rd_frame = sets[set_idx];

    // only the bits selected by wr_mask change
    always_ff @(posedge CLK) begin
        if (we) begin
            sets[set_idx] <= (sets[set_idx] & ~wr_mask) | (wr_frame & wr_mask);
        end
    end

endmodule

`default_nettype wire

// ==== cache_geom_pkg.sv ====
/*
 * cache geometry: sizes, field widths, frame bit layout
 * and the word, tag, index and way types
 */
`default_nettype none

package cache_geom_pkg;

    localparam int WORD_BITS     = 32;
    localparam int N_WAYS        = 2;
    localparam int N_SETS        = 8;
    localparam int BLOCK_WORDS   = 2;     // 128 bytes in total
    localparam int BYTE_LANES    = WORD_BITS / 8;
    localparam int BYTE_OFF_BITS = $clog2(BYTE_LANES);
    localparam int SET_BITS      = $clog2(N_SETS);
    localparam int OFFSET_BITS   = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS      = WORD_BITS - SET_BITS - OFFSET_BITS - BYTE_OFF_BITS;

    localparam logic [WORD_BITS-1:0] NONCACHE_START = 32'hF000_0000;

    // frame layout, data words at the bottom, valid on top
    localparam int TAG_LSB    = BLOCK_WORDS * WORD_BITS;
    localparam int DIRTY_BIT  = TAG_LSB + TAG_BITS;
    localparam int VALID_BIT  = DIRTY_BIT + 1;
    localparam int FRAME_BITS = VALID_BIT + 1;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [SET_BITS-1:0]    set_idx_t;
    typedef logic [OFFSET_BITS-1:0] word_off_t;
    typedef logic [$clog2(N_WAYS)-1:0] way_t;
    typedef logic [BYTE_LANES-1:0]  byte_en_t;

    // all frames of one set, way 0 in the low bits
    typedef logic [N_WAYS-1:0][FRAME_BITS-1:0] frames_t;

endpackage

`default_nettype wire

// ==== cache_lane_merge.sv ====
/*
 * result stage: array write data and mask, pass-through lane zeroing,
 * write-back word and processor read word selection
 */
`timescale 1ns/1ps
`default_nettype none

module cache_lane_merge (
    input  cache_ctrl_pkg::mem_op_t      mem_op,
    input  cache_ctrl_pkg::ctrl_state_t  state,
    input  cache_geom_pkg::way_t         hit_way,
    input  cache_geom_pkg::way_t         fill_way,
    input  cache_geom_pkg::tag_t         fill_tag,
    input  cache_geom_pkg::word_off_t    word_off,
    input  cache_geom_pkg::word_off_t    word_num,
    input  cache_geom_pkg::word_t        proc_wdata,
    input  cache_geom_pkg::byte_en_t     proc_byte_en,
    input  cache_geom_pkg::word_t        mem_rdata,
    input  cache_geom_pkg::frames_t      rd_frame,
    output cache_geom_pkg::frames_t      wr_frame,
    output cache_geom_pkg::frames_t      wr_mask,
    output cache_geom_pkg::word_t        proc_rdata,
    output cache_geom_pkg::word_t        mem_wdata
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    word_t lane_mask;
    word_t wb_word;
    word_t hit_word;

    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            lane_mask[8*b +: 8] = {8{proc_byte_en[b]}};
        end
    end

    assign wb_word  = rd_frame[fill_way][word_num*WORD_BITS +: WORD_BITS];
    assign hit_word = rd_frame[hit_way][word_off*WORD_BITS +: WORD_BITS];

    always_comb begin
        wr_frame = '0;
        wr_mask  = '0;
        unique case (state)
            IDLE: begin     // hit write, each enabled lane lands
                wr_frame[hit_way][word_off*WORD_BITS +: WORD_BITS] = proc_wdata;
                wr_mask[hit_way][word_off*WORD_BITS +: WORD_BITS]  = lane_mask;
                wr_frame[hit_way][DIRTY_BIT] = 1'b1;
                wr_mask[hit_way][DIRTY_BIT]  = 1'b1;
            end
            FETCH: begin
                wr_frame[fill_way][word_num*WORD_BITS +: WORD_BITS] = mem_rdata;
                wr_mask[fill_way][word_num*WORD_BITS +: WORD_BITS]  = '1;
                if (word_num == word_off_t'(BLOCK_WORDS - 1)) begin
                    // block complete, frame becomes a clean valid copy
                    wr_frame[fill_way][VALID_BIT]            = 1'b1;
                    wr_frame[fill_way][TAG_LSB +: TAG_BITS]  = fill_tag;
                    wr_mask[fill_way][VALID_BIT]             = 1'b1;
                    wr_mask[fill_way][DIRTY_BIT]             = 1'b1;
                    wr_mask[fill_way][TAG_LSB +: TAG_BITS]   = '1;
                end
            end
            FLUSH: begin
                for (int w = 0; w < N_WAYS; w++) begin
                    wr_mask[w][VALID_BIT] = 1'b1;   // write zeros, frame invalid and clean
                    wr_mask[w][DIRTY_BIT] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // a write in IDLE can only be a pass-through
    assign mem_wdata  = (mem_op != MEM_WRITE) ? '0 :
                        (state == IDLE)       ? (proc_wdata & lane_mask) : wb_word;
    assign proc_rdata = ((state == IDLE) && (mem_op == MEM_READ)) ? mem_rdata : hit_word;

endmodule

`default_nettype wire

// ==== cache_tag_lookup.sv ====
/*
 * decode stage: address split, tag compare, uncached range check,
 * per-set LRU bits and victim selection
 */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_lookup (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  cache_geom_pkg::word_t                         proc_addr,
    input  cache_geom_pkg::tag_t [cache_geom_pkg::N_WAYS-1:0] tags,
    input  logic [cache_geom_pkg::N_WAYS-1:0]             valids,
    input  logic [cache_geom_pkg::N_WAYS-1:0]             dirtys,
    input  logic                                          touch,
    input  cache_geom_pkg::way_t                          touch_way,
    output logic                                          hit,
    output cache_geom_pkg::way_t                          hit_way,
    output cache_geom_pkg::way_t                          victim_way,
    output logic                                          victim_dirty,
    output cache_geom_pkg::tag_t                          victim_tag,
    output logic                                          pass_through,
    output cache_geom_pkg::set_idx_t                      set_idx,
    output cache_geom_pkg::word_off_t                     word_off,
    output cache_geom_pkg::tag_t                          req_tag
);
    import cache_geom_pkg::*;

    logic [N_SETS-1:0] last_used;   // most recently used way of each set

    assign req_tag      = proc_addr[WORD_BITS-1 -: TAG_BITS];
    assign set_idx      = proc_addr[BYTE_OFF_BITS+OFFSET_BITS +: SET_BITS];
    assign word_off     = proc_addr[BYTE_OFF_BITS +: OFFSET_BITS];
    assign pass_through = (proc_addr >= NONCACHE_START);

    // uncached addresses never hit, even if a frame happens to match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (valids[w] && (tags[w] == req_tag) && !pass_through) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // two ways, so the victim is simply the other one
    assign victim_way   = ~last_used[set_idx];
    assign victim_dirty = valids[victim_way] & dirtys[victim_way];
    assign victim_tag   = tags[victim_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[set_idx] <= touch_way;
        end
    end

endmodule

`default_nettype wire

// ==== l1_cache.sv ====
/*
 * L1 data cache top: lookup, controller, lane merge and frame array
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      flush,
    output logic                      flush_done,
    input  logic                      proc_ren,
    input  logic                      proc_wen,
    input  cache_geom_pkg::word_t     proc_addr,
    input  cache_geom_pkg::word_t     proc_wdata,
    input  cache_geom_pkg::byte_en_t  proc_byte_en,
    output cache_geom_pkg::word_t     proc_rdata,
    output logic                      proc_busy,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output cache_geom_pkg::word_t     mem_addr,
    output cache_geom_pkg::word_t     mem_wdata,
    output cache_geom_pkg::byte_en_t  mem_byte_en,
    input  cache_geom_pkg::word_t     mem_rdata,
    input  logic                      mem_busy
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    mem_op_t     mem_op;
    frames_t     rd_frame, wr_frame, wr_mask;
    tag_t [N_WAYS-1:0] tags;
    logic [N_WAYS-1:0] valids, dirtys;
    logic        hit, victim_dirty, pass_through, touch, array_we;
    way_t        hit_way, victim_way, fill_way;
    tag_t        victim_tag, req_tag, fill_tag;
    set_idx_t    set_idx, array_set;
    word_off_t   word_off, word_num;

    // split the read frames into their fields
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            tags[w]   = rd_frame[w][TAG_LSB +: TAG_BITS];
            valids[w] = rd_frame[w][VALID_BIT];
            dirtys[w] = rd_frame[w][DIRTY_BIT];
        end
    end

    cache_tag_lookup u_lookup (
        .CLK, .nRST, .proc_addr, .tags, .valids, .dirtys,
        .touch, .touch_way(hit_way),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .pass_through, .set_idx, .word_off, .req_tag
    );

    cache_data_array u_array (
        .CLK, .set_idx(array_set), .we(array_we), .wr_frame, .wr_mask, .rd_frame
    );

    cache_controller u_ctrl (
        .CLK, .nRST, .proc_ren, .proc_wen, .proc_addr, .proc_byte_en,
        .flush, .hit, .pass_through, .victim_dirty, .mem_busy,
        .victim_way, .victim_tag, .req_tag, .set_idx,
        .frame_valid(valids), .frame_dirty(dirtys), .frame_tag(tags),
        .state, .mem_op, .mem_ren, .mem_wen, .mem_addr, .mem_byte_en,
        .array_we, .array_set, .fill_way, .fill_tag, .word_num,
        .touch, .proc_busy, .flush_done
    );

    cache_lane_merge u_merge (
        .mem_op, .state, .hit_way, .fill_way, .fill_tag, .word_off, .word_num,
        .proc_wdata, .proc_byte_en, .mem_rdata, .rd_frame,
        .wr_frame, .wr_mask, .proc_rdata, .mem_wdata
    );

endmodule

`default_nettype wire

// ==== l1_cache_properties.sv ====
/*
 * concurrent checks on the cache ports: exclusive memory strobes,
 * single-cycle flush_done, no busy on an idle processor
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_properties (
    input logic CLK,
    input logic nRST,
    input logic flush,
    input logic proc_ren,
    input logic proc_wen,
    input logic proc_busy,
    input logic mem_ren,
    input logic mem_wen,
    input logic flush_done
);
    import cache_geom_pkg::*;

    logic [$clog2(N_SETS):0] sweep_cnt;     // cycles since reset, stops at N_SETS
    logic                    flushing;      // from an accepted flush up to flush_done
    int                      n_failed = 0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sweep_cnt <= '0;
            flushing  <= 1'b0;
        end else begin
            if (sweep_cnt != N_SETS) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            if (flush) begin
                flushing <= 1'b1;
            end else if (flush_done) begin
                flushing <= 1'b0;
            end
        end
    end

    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            n_failed++;
            $error("mem_ren and mem_wen high in the same cycle");
        end

    flush_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            n_failed++;
            $error("flush_done held for more than one cycle");
        end

    // the reset sweep takes N_SETS cycles
    idle_not_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (sweep_cnt == N_SETS && !flushing && !proc_ren && !proc_wen) |-> !proc_busy)
        else begin
            n_failed++;
            $error("proc_busy high without a request");
        end

endmodule

`default_nettype wire

// ==== src.f ====
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_tag_lookup.sv
cache_data_array.sv
cache_controller.sv
cache_lane_merge.sv
l1_cache.sv
l1_cache_properties.sv
tb_l1_cache.sv

// ==== tb_l1_cache.sv ====
/*
 * testbench for the L1 cache: clock and reset, memory model with
 * random busy cycles, stimulus table and checks against a memory image
 */
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
    import cache_geom_pkg::*;

    localparam int N_ENTRIES   = 24;
    localparam int CYCLE_LIMIT = N_ENTRIES * 40 + 400;
    localparam int MEM_WORDS   = 512;
    localparam word_t INIT_XOR = 32'h5A5A_5A5A;

    localparam int OP_RD    = 0;
    localparam int OP_WR    = 1;
    localparam int OP_FL    = 2;
    localparam int CHK_NONE = 0;
    localparam int CHK_HIT  = 1;    // done in the request cycle
    localparam int CHK_MEM  = 2;    // has to read memory again

    logic     CLK, nRST, flush, flush_done;
    logic     proc_ren, proc_wen, proc_busy;
    word_t    proc_addr, proc_wdata, proc_rdata;
    byte_en_t proc_byte_en, mem_byte_en;
    logic     mem_ren, mem_wen;
    logic     mem_busy = 1'b0;
    word_t    mem_addr, mem_wdata, mem_rdata;

    word_t    mem [MEM_WORDS];
    word_t    exp_mem [MEM_WORDS];      // image memory must hold after a flush
    integer   seed = 32'h7ac6;
    int       wait_cnt = 0;
    int       ren_rises = 0;
    logic     ren_q = 1'b0;
    int       cycles = 0;

    int       op_tab [N_ENTRIES];
    word_t    addr_tab [N_ENTRIES];
    byte_en_t be_tab [N_ENTRIES];
    word_t    wdata_tab [N_ENTRIES];
    word_t    exp_tab [N_ENTRIES];
    int       chk_tab [N_ENTRIES];
    int       n_ent;

    l1_cache dut0 (
        .CLK, .nRST, .flush, .flush_done,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_byte_en,
        .proc_rdata, .proc_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_rdata, .mem_busy
    );

    bind l1_cache l1_cache_properties props0 (
        .CLK, .nRST, .flush, .proc_ren, .proc_wen, .proc_busy,
        .mem_ren, .mem_wen, .flush_done
    );

    // low addresses and the uncached window share one small array
    function automatic int mem_index(input word_t a);
        return int'({a[31], a[9:2]});
    endfunction

    function automatic word_t index_addr(input int i);
        word_t a;
        a = {22'd0, i[7:0], 2'b00};
        if (i[8]) begin
            a = a | NONCACHE_START;
        end
        return a;
    endfunction

    function automatic word_t init_word(input word_t a);
        return a ^ INIT_XOR;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t nw, input byte_en_t be);
        word_t r;
        r = old;
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic add_entry(input int op, input word_t addr, input byte_en_t be,
                             input word_t wdata, input word_t exp, input int chk);
        op_tab[n_ent]    = op;
        addr_tab[n_ent]  = addr;
        be_tab[n_ent]    = be;
        wdata_tab[n_ent] = wdata;
        exp_tab[n_ent]   = exp;
        chk_tab[n_ent]   = chk;
        n_ent++;
    endtask

    task automatic build_table();
        n_ent = 0;
        // read miss, then the other word of the block
        add_entry(OP_RD, 32'h108, 4'hF, 0, init_word(32'h108), CHK_NONE);
        add_entry(OP_RD, 32'h10C, 4'hF, 0, init_word(32'h10C), CHK_HIT);
        add_entry(OP_WR, 32'h108, 4'b0010, 32'hAABB_CCDD, 0, CHK_HIT);     // one byte
        add_entry(OP_WR, 32'h10C, 4'b1100, 32'h1122_3344, 0, CHK_HIT);     // upper half
        add_entry(OP_RD, 32'h108, 4'hF, 0,
                  (init_word(32'h108) & 32'hFFFF_00FF) | 32'h0000_CC00, CHK_HIT);
        add_entry(OP_RD, 32'h10C, 4'hF, 0,
                  (init_word(32'h10C) & 32'h0000_FFFF) | 32'h1122_0000, CHK_HIT);
        add_entry(OP_WR, 32'h210, 4'b0001, 32'h0000_00EE, 0, CHK_NONE);    // write miss
        add_entry(OP_RD, 32'h210, 4'hF, 0,
                  (init_word(32'h210) & 32'hFFFF_FF00) | 32'hEE, CHK_HIT);
        // set 0 holds 0x000 and 0x040, then 0x080 pushes out the older one
        add_entry(OP_WR, 32'h000, 4'hF, 32'hDEAD_0000, 0, CHK_NONE);
        add_entry(OP_WR, 32'h044, 4'hF, 32'hBEEF_0044, 0, CHK_NONE);
        add_entry(OP_RD, 32'h080, 4'hF, 0, init_word(32'h080), CHK_NONE);
        add_entry(OP_RD, 32'h000, 4'hF, 0, 32'hDEAD_0000, CHK_MEM);
        add_entry(OP_RD, 32'h044, 4'hF, 0, 32'hBEEF_0044, CHK_MEM);
        add_entry(OP_RD, 32'h004, 4'hF, 0, init_word(32'h004), CHK_HIT);
        add_entry(OP_WR, 32'hF000_0010, 4'b0001, 32'h1234_5678, 0, CHK_NONE);
        add_entry(OP_RD, 32'hF000_0010, 4'hF, 0,
                  (init_word(32'hF000_0010) & 32'hFFFF_FF00) | 32'h78, CHK_NONE);
        add_entry(OP_WR, 32'h3F8, 4'hF, 32'hCAFE_F00D, 0, CHK_NONE);
        add_entry(OP_WR, 32'h10C, 4'b0011, 32'h0000_BEEF, 0, CHK_HIT);
        add_entry(OP_FL, 0, 0, 0, 0, CHK_NONE);
        // everything was invalidated, so these all refetch
        add_entry(OP_RD, 32'h10C, 4'hF, 0, 32'h1122_BEEF, CHK_MEM);
        add_entry(OP_RD, 32'h3F8, 4'hF, 0, 32'hCAFE_F00D, CHK_MEM);
        add_entry(OP_RD, 32'h3FC, 4'hF, 0, init_word(32'h3FC), CHK_HIT);
        add_entry(OP_RD, 32'h210, 4'hF, 0,
                  (init_word(32'h210) & 32'hFFFF_FF00) | 32'hEE, CHK_MEM);
        add_entry(OP_RD, 32'h000, 4'hF, 0, 32'hDEAD_0000, CHK_MEM);
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // memory model, a word moves when a strobe is high and mem_busy is low
    assign mem_rdata = mem[{mem_addr[31], mem_addr[9:2]}];

    always @(posedge CLK) begin
        ren_q <= mem_ren;
        if (mem_ren && !ren_q) begin
            ren_rises <= ren_rises + 1;
        end
        if (mem_ren || mem_wen) begin
            if (!mem_busy) begin
                if (mem_wen) begin
                    mem[mem_index(mem_addr)] <= merge_lanes(mem[mem_index(mem_addr)],
                                                            mem_wdata, mem_byte_en);
                    check_value("mem_wdata outside mem_byte_en",
                                mem_wdata & ~{{8{mem_byte_en[3]}}, {8{mem_byte_en[2]}},
                                              {8{mem_byte_en[1]}}, {8{mem_byte_en[0]}}}, '0);
                end
                wait_cnt <= $unsigned($random(seed)) % 3;   // busy cycles before the next word
            end else if (wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(negedge CLK) begin
        mem_busy <= (wait_cnt != 0);
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: test still running after %0d cycles", cycles));
        end
    end

    // bound port assertions count their failures
    always @(negedge CLK) begin
        if (dut0.props0.n_failed != 0) begin
            stop_on_error("a bound assertion on the cache ports failed");
        end
    end

    initial begin
        int waits;
        int rises_before;
        int idx;
        nRST         = 1'b0;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = init_word(index_addr(i));
            exp_mem[i] = mem[i];
        end
        build_table();
        repeat (2) @(negedge CLK);
        nRST = 1'b1;

        for (int e = 0; e < n_ent; e++) begin
            @(negedge CLK);
            if (op_tab[e] == OP_FL) begin
                proc_ren = 1'b0;
                proc_wen = 1'b0;
                flush    = 1'b1;
                @(negedge CLK);
                flush = 1'b0;
                do @(posedge CLK); while (!flush_done);
                @(negedge CLK);     // last write-back word has landed
                for (int i = 0; i < MEM_WORDS; i++) begin
                    check_value($sformatf("mem[%h]", index_addr(i)), mem[i], exp_mem[i]);
                end
            end else begin
                proc_addr    = addr_tab[e];
                proc_wdata   = wdata_tab[e];
                proc_byte_en = be_tab[e];
                proc_ren     = (op_tab[e] == OP_RD);
                proc_wen     = (op_tab[e] == OP_WR);
                rises_before = ren_rises;
                waits        = 0;
                @(posedge CLK);
                while (proc_busy) begin
                    waits++;
                    @(posedge CLK);
                end
                idx = mem_index(addr_tab[e]);
                if (op_tab[e] == OP_WR) begin
                    exp_mem[idx] = merge_lanes(exp_mem[idx], wdata_tab[e], be_tab[e]);
                end else begin
                    check_value($sformatf("proc_rdata at %h", addr_tab[e]),
                                proc_rdata, exp_tab[e]);
                end
                if (chk_tab[e] == CHK_HIT) begin
                    check_value("proc_busy cycles on hit", word_t'(waits), '0);
                end
                if (chk_tab[e] == CHK_MEM) begin
                    assert (ren_rises > rises_before) else begin
                        stop_on_error($sformatf("read of %h was served without a memory read",
                                                addr_tab[e]));
                    end
                end
            end
        end

        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        if (dut0.props0.n_failed != 0) begin
            stop_on_error("a bound assertion on the cache ports failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
